// File: source/branch_pkg.sv
// shared widths, counts and vector types of the branch unit
// also holds the field layout of the table write address

package branch_pkg;

    // --------------------------------------------------
    // program counter and threads

    localparam int pc_width     = 10;
    localparam int thread_count = 8;
    localparam int thread_width = 3;

    typedef logic [pc_width-1:0]     pc_t;
    typedef logic [thread_width-1:0] thread_t;

    // --------------------------------------------------
    // result flags and the condition code that picks one of them

    localparam int flags_width = 8;
    localparam int cond_width  = 3;

    typedef logic [flags_width-1:0] flags_t;
    typedef logic [cond_width-1:0]  cond_t;

    // --------------------------------------------------
    // branch entries and the write address layout
    // the thread sits in the low bits and the entry number above it

    localparam int branch_count     = 2;
    localparam int entry_width      = 1;
    localparam int write_addr_width = thread_width + entry_width;
    localparam int thread_field_lsb = 0;
    localparam int entry_field_lsb  = thread_width;

    typedef logic [entry_width-1:0]      entry_t;
    typedef logic [write_addr_width-1:0] write_addr_t;

    // --------------------------------------------------
    // pipeline timing

    // cycles from a pc at the input to its result at the outputs
    localparam int check_latency = 4;
    // brings a registered jump back to the same thread's stage 3
    localparam int recirc_depth  = thread_count - 1;

endpackage

// File: source/delay_line.sv
// resettable shift register of configurable depth and width

`timescale 1ns/10ps

module delay_line #(
    parameter int depth = 1,
    parameter int width = 1
) (
    input  logic             clock,
    input  logic             reset,
    input  logic [width-1:0] data_in,
    output logic [width-1:0] data_out
);

    // stage 0 takes the input, the last stage feeds the output
    logic [width-1:0] stages [depth];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= data_in;
            // a depth of one leaves this loop empty
            for (int i = 1; i < depth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign data_out = stages[depth-1];

endmodule

// File: source/thread_counter.sv
// round-robin counter for the thread issuing this cycle
// plus a check that it only ever steps by one

`timescale 1ns/10ps

module thread_counter (
    input  logic                clock,
    input  logic                reset,
    output branch_pkg::thread_t read_thread
);

    // threads issue in a fixed order, one per clock, starting at thread 0
    always_ff @(posedge clock) begin
        if (reset) begin
            read_thread <= '0;
        end else if (read_thread == branch_pkg::thread_t'(branch_pkg::thread_count - 1)) begin
            read_thread <= '0;
        end else begin
            read_thread <= read_thread + 1'b1;
        end
    end

    // --------------------------------------------------
    // every table and pipeline slot assumes a strict rotation, so a
    // skipped or repeated thread would misalign all branch entries

    property p_round_robin;
        @(posedge clock) disable iff (reset)
        !$past(reset) |->
            read_thread == branch_pkg::thread_t'(
                (int'($past(read_thread)) + 1) % branch_pkg::thread_count);
    endproperty

    a_round_robin : assert property (p_round_robin)
        else $error("thread counter left the round-robin order");

endmodule

// File: source/branch_table.sv
// per-thread storage with one write port and a registered read
// clears every word on reset

`timescale 1ns/10ps

module branch_table #(
    parameter int word_width = branch_pkg::pc_width
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wren,
    input  branch_pkg::thread_t   write_addr,
    input  logic [word_width-1:0] write_data,
    input  branch_pkg::thread_t   read_addr,
    output logic [word_width-1:0] read_data
);

    // one word per hardware thread
    logic [word_width-1:0] words [branch_pkg::thread_count];

    // --------------------------------------------------
    // write port
    // the new word becomes visible on the edge after the strobe

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < branch_pkg::thread_count; i++) begin
                words[i] <= '0;
            end
        end else if (wren) begin
            words[write_addr] <= write_data;
        end
    end

    // --------------------------------------------------
    // read port
    // a read in the same cycle as a write to that word returns the old word

    always_ff @(posedge clock) begin
        if (reset) begin
            read_data <= '0;
        end else begin
            read_data <= words[read_addr];
        end
    end

    // an unknown address would corrupt some unknown thread's entry
    a_write_addr_known : assert property (
        @(posedge clock) disable iff (reset) wren |-> !$isunknown(write_addr))
        else $error("branch table written with an unknown address");

endmodule

// File: source/branch_check.sv
// one branch entry with origin, destination and condition tables
// four-stage origin compare, flag select and masking pipeline
// jump recirculation for instructions re-issued while waiting on I/O

`timescale 1ns/10ps

module branch_check (
    input  logic                clock,
    input  logic                reset,
    input  branch_pkg::pc_t     pc,
    input  branch_pkg::flags_t  flags,
    input  logic                io_ready_previous,
    input  branch_pkg::thread_t read_thread,
    input  logic                wren_origin,
    input  logic                wren_destination,
    input  logic                wren_condition,
    input  branch_pkg::thread_t table_addr,
    input  branch_pkg::pc_t     write_data,
    output branch_pkg::pc_t     entry_destination,
    output logic                entry_jump
);

    // --------------------------------------------------
    // stage 1: table reads and the aligned pc

    branch_pkg::pc_t   origin_s1;
    branch_pkg::pc_t   destination_s1;
    branch_pkg::cond_t condition_s1;
    branch_pkg::pc_t   pc_s1;

    branch_table #(.word_width(branch_pkg::pc_width)) origin_table (
        .clock      (clock),
        .reset      (reset),
        .wren       (wren_origin),
        .write_addr (table_addr),
        .write_data (write_data),
        .read_addr  (read_thread),
        .read_data  (origin_s1)
    );

    branch_table #(.word_width(branch_pkg::pc_width)) destination_table (
        .clock      (clock),
        .reset      (reset),
        .wren       (wren_destination),
        .write_addr (table_addr),
        .write_data (write_data),
        .read_addr  (read_thread),
        .read_data  (destination_s1)
    );

    // conditions only keep the low bits of the write word
    branch_table #(.word_width(branch_pkg::cond_width)) condition_table (
        .clock      (clock),
        .reset      (reset),
        .wren       (wren_condition),
        .write_addr (table_addr),
        .write_data (write_data[branch_pkg::cond_width-1:0]),
        .read_addr  (read_thread),
        .read_data  (condition_s1)
    );

    // the pc waits one cycle so it lines up with the table read data
    delay_line #(.depth(1), .width(branch_pkg::pc_width)) pc_align (
        .clock    (clock),
        .reset    (reset),
        .data_in  (pc),
        .data_out (pc_s1)
    );

    // --------------------------------------------------
    // stage 2: origin hit, raw destination and the condition that
    // lines up with the flags arriving in this cycle

    logic              origin_hit_s2;
    branch_pkg::pc_t   destination_s2;
    branch_pkg::cond_t condition_s2;

    // --------------------------------------------------
    // stage 3: selected flag, delayed hit and destination masked by the hit

    logic            flag_s3;
    logic            origin_hit_s3;
    branch_pkg::pc_t destination_masked_s3;

    always_ff @(posedge clock) begin
        if (reset) begin
            origin_hit_s2         <= 1'b0;
            destination_s2        <= '0;
            condition_s2          <= '0;
            flag_s3               <= 1'b0;
            origin_hit_s3         <= 1'b0;
            destination_masked_s3 <= '0;
        end else begin
            origin_hit_s2         <= (pc_s1 == origin_s1);
            destination_s2        <= destination_s1;
            condition_s2          <= condition_s1;
            // flags belong to the previous instruction of the thread now in stage 2
            flag_s3               <= flags[condition_s2];
            origin_hit_s3         <= origin_hit_s2;
            destination_masked_s3 <= origin_hit_s2 ? destination_s2 : '0;
        end
    end

    // I/O re-issue rule
    // when the previous instruction stalled on I/O it was annulled, so its
    // flags are meaningless and this pass must repeat the decision taken on
    // the thread's previous pass
    logic jump_previous;
    logic flag_used;

    always_comb begin
        if (io_ready_previous) begin
            flag_used = flag_s3;
        end else begin
            flag_used = jump_previous;
        end
    end

    // a jump needs both the origin match and the selected flag
    logic jump_s3;

    assign jump_s3 = flag_used & origin_hit_s3;

    // --------------------------------------------------
    // stage 4: registered outputs, all zero unless the entry jumps

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_jump        <= 1'b0;
            entry_destination <= '0;
        end else begin
            entry_jump        <= jump_s3;
            entry_destination <= flag_used ? destination_masked_s3 : '0;
        end
    end

    // the registered jump comes back to stage 3 exactly one thread round later
    delay_line #(.depth(branch_pkg::recirc_depth), .width(1)) jump_recirc (
        .clock    (clock),
        .reset    (reset),
        .data_in  (entry_jump),
        .data_out (jump_previous)
    );

    // the top level ORs all entries together, so an idle entry must
    // present an all-zero destination or it would corrupt another's jump
    a_idle_destination_zero : assert property (
        @(posedge clock) disable iff (reset) !entry_jump |-> entry_destination == '0)
        else $error("branch entry drives a destination without a jump");

endmodule

// File: source/branch_unit.sv
// top of the branch unit with the shared thread counter
// table write address decode across the branch entries
// OR-reduction of the entry outputs into one destination and jump

`timescale 1ns/10ps

module branch_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  branch_pkg::pc_t         pc,
    input  branch_pkg::flags_t      flags,
    input  logic                    io_ready_previous,
    input  logic                    wren_origin,
    input  logic                    wren_destination,
    input  logic                    wren_condition,
    input  branch_pkg::write_addr_t write_addr,
    input  branch_pkg::pc_t         write_data,
    output branch_pkg::pc_t         branch_destination,
    output logic                    jump
);

    // --------------------------------------------------
    // one thread counter keeps every entry on the same slot

    branch_pkg::thread_t read_thread;

    thread_counter threads (
        .clock       (clock),
        .reset       (reset),
        .read_thread (read_thread)
    );

    // thread field of the write address, shared by all entries
    branch_pkg::thread_t table_addr;
    branch_pkg::entry_t  write_entry;

    assign table_addr  = write_addr[branch_pkg::thread_field_lsb +: branch_pkg::thread_width];
    assign write_entry = write_addr[branch_pkg::entry_field_lsb +: branch_pkg::entry_width];

    // --------------------------------------------------
    // branch entries

    branch_pkg::pc_t               entry_destination [branch_pkg::branch_count];
    logic [branch_pkg::branch_count-1:0] entry_jump;

    for (genvar e = 0; e < branch_pkg::branch_count; e++) begin : entries
        logic selected;

        // only the entry named in the address sees the write strobes
        assign selected = (write_entry == branch_pkg::entry_t'(e));

        branch_check check (
            .clock             (clock),
            .reset             (reset),
            .pc                (pc),
            .flags             (flags),
            .io_ready_previous (io_ready_previous),
            .read_thread       (read_thread),
            .wren_origin       (wren_origin & selected),
            .wren_destination  (wren_destination & selected),
            .wren_condition    (wren_condition & selected),
            .table_addr        (table_addr),
            .write_data        (write_data),
            .entry_destination (entry_destination[e]),
            .entry_jump        (entry_jump[e])
        );
    end

    // --------------------------------------------------
    // idle entries output zeros, so an OR merges them safely

    always_comb begin
        branch_destination = '0;
        for (int e = 0; e < branch_pkg::branch_count; e++) begin
            branch_destination = branch_destination | entry_destination[e];
        end
    end

    assign jump = |entry_jump;

endmodule

// File: verif/tb_branch_unit.sv
// directed testbench for the branch unit
// holds a cycle model of the branch tables, the check task, a watchdog and the tests

`timescale 1ns/10ps

module tb_branch_unit;

    logic                    clock;
    logic                    reset;
    branch_pkg::pc_t         pc;
    branch_pkg::flags_t      flags;
    logic                    io_ready_previous;
    logic                    wren_origin;
    logic                    wren_destination;
    logic                    wren_condition;
    branch_pkg::write_addr_t write_addr;
    branch_pkg::pc_t         write_data;
    branch_pkg::pc_t         branch_destination;
    logic                    jump;

    branch_unit DUT (
        .clock              (clock),
        .reset              (reset),
        .pc                 (pc),
        .flags              (flags),
        .io_ready_previous  (io_ready_previous),
        .wren_origin        (wren_origin),
        .wren_destination   (wren_destination),
        .wren_condition     (wren_condition),
        .write_addr         (write_addr),
        .write_data         (write_data),
        .branch_destination (branch_destination),
        .jump               (jump)
    );

    // --------------------------------------------------
    // reference model of the tables and the recirculated jumps

    branch_pkg::pc_t   model_origin [branch_pkg::branch_count][branch_pkg::thread_count];
    branch_pkg::pc_t   model_dest   [branch_pkg::branch_count][branch_pkg::thread_count];
    branch_pkg::cond_t model_cond   [branch_pkg::branch_count][branch_pkg::thread_count];
    logic              model_prev   [branch_pkg::branch_count][branch_pkg::thread_count];

    // per-slot history indexed by the cycle number modulo 8
    // flags go out two cycles after their pc and io_ready_previous three cycles after
    branch_pkg::flags_t ring_flags [8];
    logic               ring_io    [8];
    logic               ring_jump  [8];
    branch_pkg::pc_t    ring_dest  [8];

    int cycle       = 0;
    int error_count = 0;
    int check_count = 0;
    int seed        = 69343;

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // six tests of at most 200 cycles each, plus the reset time
    initial begin
        repeat (6 * 200 + 10) @(posedge clock);
        $display("watchdog expired before the tests finished");
        $display("Errors found");
        $finish;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
        end
    endtask

    // drives one issue slot at the falling edge, checks the slot that left the pipeline,
    // predicts the new slot and applies the table write
    // wr_sel 0 means no write, 1 writes the origin, 2 the destination and 3 the condition
    task automatic step_cycle(input branch_pkg::pc_t slot_pc, input branch_pkg::flags_t slot_f,
                              input logic slot_io, input int wr_sel,
                              input branch_pkg::write_addr_t wr_addr,
                              input branch_pkg::pc_t wr_data);
        int              thread;
        int              wr_entry;
        int              wr_thread;
        int              done_slot;
        logic            hit;
        logic            flag;
        logic            entry_jump;
        logic            jump_sum;
        branch_pkg::pc_t dest_sum;
        thread    = cycle % branch_pkg::thread_count;
        done_slot = cycle - branch_pkg::check_latency;
        wr_entry  = int'(wr_addr[branch_pkg::entry_field_lsb]);
        wr_thread = int'(wr_addr[branch_pkg::thread_width-1:0]);
        pc                = slot_pc;
        flags             = ring_flags[(cycle - 2) & 7];
        io_ready_previous = ring_io[(cycle - 3) & 7];
        wren_origin       = (wr_sel == 1);
        wren_destination  = (wr_sel == 2);
        wren_condition    = (wr_sel == 3);
        write_addr        = wr_addr;
        write_data        = wr_data;
        // outputs at this edge belong to the slot issued one latency ago
        check_value(jump, ring_jump[done_slot & 7], $sformatf("jump of slot %0d", done_slot));
        check_value(branch_destination, ring_dest[done_slot & 7],
                    $sformatf("branch_destination of slot %0d", done_slot));
        jump_sum = 1'b0;
        dest_sum = '0;
        for (int e = 0; e < branch_pkg::branch_count; e++) begin
            hit = (model_origin[e][thread] == slot_pc);
            // a stalled I/O instruction repeats the thread's previous decision
            flag = slot_io ? slot_f[model_cond[e][thread]] : model_prev[e][thread];
            entry_jump = hit & flag;
            model_prev[e][thread] = entry_jump;
            jump_sum = jump_sum | entry_jump;
            if (entry_jump) begin
                dest_sum = dest_sum | model_dest[e][thread];
            end
        end
        ring_flags[cycle & 7] = slot_f;
        ring_io[cycle & 7]    = slot_io;
        ring_jump[cycle & 7]  = jump_sum;
        ring_dest[cycle & 7]  = dest_sum;
        // the read of this slot saw the old word, so the write lands after the prediction
        if (wr_sel == 1) begin
            model_origin[wr_entry][wr_thread] = wr_data;
        end else if (wr_sel == 2) begin
            model_dest[wr_entry][wr_thread] = wr_data;
        end else if (wr_sel == 3) begin
            model_cond[wr_entry][wr_thread] = wr_data[branch_pkg::cond_width-1:0];
        end
        cycle++;
        @(negedge clock);
    endtask

    // an all-ones pc matches none of the origins the tests program
    task automatic idle_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            step_cycle('1, '0, 1'b1, 0, '0, '0);
        end
    endtask

    task automatic align_to_thread(input int thread);
        while (cycle % branch_pkg::thread_count != thread) begin
            idle_cycles(1);
        end
    endtask

    task automatic write_entry(input logic entry, input branch_pkg::thread_t thread,
                               input branch_pkg::pc_t origin, input branch_pkg::pc_t dest,
                               input branch_pkg::cond_t cond);
        branch_pkg::write_addr_t addr;
        addr = {entry, thread};
        step_cycle('1, '0, 1'b1, 1, addr, origin);
        step_cycle('1, '0, 1'b1, 2, addr, dest);
        step_cycle('1, '0, 1'b1, 3, addr, branch_pkg::pc_t'(cond));
    endtask

    // issues one slot for a thread and checks the outputs one latency later
    task automatic probe_slot(input int thread, input branch_pkg::pc_t slot_pc,
                              input branch_pkg::flags_t slot_f, input logic slot_io,
                              input logic exp_jump, input branch_pkg::pc_t exp_dest,
                              input string what);
        align_to_thread(thread);
        step_cycle(slot_pc, slot_f, slot_io, 0, '0, '0);
        idle_cycles(branch_pkg::check_latency - 1);
        check_value(jump, exp_jump, {what, " jump"});
        check_value(branch_destination, exp_dest, {what, " destination"});
    endtask

    task automatic report_test(input string name, input int errors_at_start);
        $display("%s finished with %0d mismatches", name, error_count - errors_at_start);
    endtask

    // --------------------------------------------------
    // tests

    task automatic idle_after_reset();
        int              start;
        branch_pkg::pc_t p;
        start = error_count;
        for (int i = 0; i < 40; i++) begin
            // cleared entries match pc 0, so every other slot uses it
            p = (i % 2 == 0) ? '0 : branch_pkg::pc_t'($random(seed));
            step_cycle(p, '0, 1'b1, 0, '0, '0);
            check_value(jump, 0, "jump after reset");
            check_value(branch_destination, 0, "destination after reset");
        end
        report_test("idle_after_reset", start);
    endtask

    task automatic taken_branch();
        int start;
        start = error_count;
        write_entry(1'b0, 3'd3, 10'h12A, 10'h055, 3'd5);
        probe_slot(3, 10'h12A, 8'h20, 1'b1, 1'b1, 10'h055, "taken branch");
        // the seven slots of the other threads stay quiet
        for (int i = 0; i < 7; i++) begin
            idle_cycles(1);
            check_value(jump, 0, "jump of another thread");
            check_value(branch_destination, 0, "destination of another thread");
        end
        report_test("taken_branch", start);
    endtask

    task automatic not_taken_branches();
        int start;
        start = error_count;
        // 0xDE has every flag but bit 5 and bit 0 set
        probe_slot(3, 10'h12A, 8'hDE, 1'b1, 1'b0, 10'h000, "flag clear");
        probe_slot(3, 10'h12B, 8'h20, 1'b1, 1'b0, 10'h000, "pc mismatch");
        report_test("not_taken_branches", start);
    endtask

    task automatic random_two_entries();
        int                 start;
        int                 thread;
        branch_pkg::pc_t    p;
        branch_pkg::flags_t f;
        logic               io;
        start = error_count;
        write_entry(1'b1, 3'd6, 10'h2B7, 10'h1C4, 3'd2);
        write_entry(1'b0, 3'd2, 10'h0E1, 10'h3A9, 3'd7);
        for (int i = 0; i < 96; i++) begin
            thread = cycle % branch_pkg::thread_count;
            p = branch_pkg::pc_t'($random(seed));
            // about half the slots of the programmed threads carry their origin
            if ($random(seed) & 1) begin
                if (thread == 6) begin
                    p = 10'h2B7;
                end else if (thread == 2) begin
                    p = 10'h0E1;
                end else if (thread == 3) begin
                    p = 10'h12A;
                end
            end
            f  = branch_pkg::flags_t'($random(seed)) & 8'hFE;
            io = (($random(seed) & 3) != 0);
            step_cycle(p, f, io, 0, '0, '0);
        end
        report_test("random_two_entries", start);
    endtask

    task automatic io_reissue();
        int start;
        start = error_count;
        probe_slot(3, 10'h12A, 8'h20, 1'b1, 1'b1, 10'h055, "jump before stall");
        // the stalled pass repeats the jump although its flag is clear
        probe_slot(3, 10'h12A, 8'h00, 1'b0, 1'b1, 10'h055, "stalled repeat");
        probe_slot(3, 10'h12A, 8'h00, 1'b1, 1'b0, 10'h000, "pass without jump");
        probe_slot(3, 10'h12A, 8'h20, 1'b0, 1'b0, 10'h000, "stalled after no jump");
        report_test("io_reissue", start);
    endtask

    task automatic overwrite_during_read();
        int start;
        start = error_count;
        align_to_thread(3);
        step_cycle(10'h12A, 8'h20, 1'b1, 2, 4'h3, 10'h2F0);
        idle_cycles(branch_pkg::check_latency - 1);
        check_value(jump, 1, "jump during overwrite");
        check_value(branch_destination, 10'h055, "old destination during overwrite");
        probe_slot(3, 10'h12A, 8'h20, 1'b1, 1'b1, 10'h2F0, "new destination");
        report_test("overwrite_during_read", start);
    endtask

    // --------------------------------------------------
    // main sequence

    initial begin
        reset             = 1'b1;
        pc                = '0;
        flags             = '0;
        io_ready_previous = 1'b1;
        wren_origin       = 1'b0;
        wren_destination  = 1'b0;
        wren_condition    = 1'b0;
        write_addr        = '0;
        write_data        = '0;
        for (int e = 0; e < branch_pkg::branch_count; e++) begin
            for (int t = 0; t < branch_pkg::thread_count; t++) begin
                model_origin[e][t] = '0;
                model_dest[e][t]   = '0;
                model_cond[e][t]   = '0;
                model_prev[e][t]   = 1'b0;
            end
        end
        for (int i = 0; i < 8; i++) begin
            ring_flags[i] = '0;
            ring_io[i]    = 1'b1;
            ring_jump[i]  = 1'b0;
            ring_dest[i]  = '0;
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        // thread 0 issues in the first cycle after reset
        reset = 1'b0;
        idle_after_reset();
        taken_branch();
        not_taken_branches();
        random_two_entries();
        io_reissue();
        overwrite_during_read();
        idle_cycles(8);
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tb.f
source/branch_pkg.sv
source/delay_line.sv
source/thread_counter.sv
source/branch_table.sv
source/branch_check.sv
source/branch_unit.sv
verif/tb_branch_unit.sv

// File: run.sh
#!/bin/sh
# build the branch unit testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_branch_unit -o tb_branch_unit -f tb.f > build.log 2>&1 \
    && ./obj_dir/tb_branch_unit > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -qx "No errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
